// ==== hw/cache_settings.svh ====
`ifndef CACHE_SETTINGS_SVH
`define CACHE_SETTINGS_SVH

// address split: tag | index | offset
`define CACHE_TAG_W 20
`define CACHE_INDEX_W 8
`define CACHE_OFFSET_W 4

// data word and line geometry
`define CACHE_WORD_W 32
`define CACHE_BANKS 4

// one set per index value
`define CACHE_SETS (1 << `CACHE_INDEX_W)

`endif

// ==== hw/cache_pkg.sv ====
`include "cache_settings.svh"

package cache_pkg;

    // main FSM, one-hot
    typedef enum logic [4:0] {
        IDLE    = 5'b00001,
        LOOKUP  = 5'b00010,
        MISS    = 5'b00100,
        REPLACE = 5'b01000,
        REFILL  = 5'b10000
    } state_t;

    // one CPU request as seen at the port
    typedef struct packed {
        logic                       op;
        logic [`CACHE_TAG_W-1:0]    tag;
        logic [`CACHE_INDEX_W-1:0]  index;
        logic [`CACHE_OFFSET_W-1:0] offset;
        logic [`CACHE_WORD_W/8-1:0] wstrb;
        logic [`CACHE_WORD_W-1:0]   wdata;
    } cpu_req_t;

    typedef struct packed {
        logic [`CACHE_TAG_W-1:0]    tag;
        logic [`CACHE_INDEX_W-1:0]  index;
        logic [`CACHE_OFFSET_W-1:0] offset;
    } addr_fields_t;

    // memory address, flat or split
    typedef union packed {
        logic [`CACHE_TAG_W+`CACHE_INDEX_W+`CACHE_OFFSET_W-1:0] word;
        addr_fields_t                                           fields;
    } cache_addr_u;

    // state of one way for the set last presented
    typedef struct packed {
        logic                                        hit;
        logic                                        valid;
        logic                                        dirty;
        logic [`CACHE_TAG_W-1:0]                     tag;
        logic [`CACHE_BANKS-1:0][`CACHE_WORD_W-1:0]  line;
    } way_stat_t;

    // write into one way, data word shared by all banks
    typedef struct packed {
        logic [`CACHE_BANKS-1:0][`CACHE_WORD_W/8-1:0] wstrb;
        logic [`CACHE_WORD_W-1:0]                     wdata;
        logic                                         tag_we;
        logic                                         dirty_we;
        logic                                         dirty;
    } way_wr_t;

endpackage

// ==== hw/bank_ram.sv ====
`timescale 1ns/100ps
`include "cache_settings.svh"

module bank_ram (
    input  logic                        clk_g,
    input  logic [`CACHE_INDEX_W-1:0]   addr,
    input  logic [`CACHE_WORD_W/8-1:0]  wstrb,
    input  logic [`CACHE_WORD_W-1:0]    wdata,
    output logic [`CACHE_WORD_W-1:0]    rdata
);

    logic [`CACHE_WORD_W-1:0] mem [`CACHE_SETS];

    // byte lanes written independently
    always_ff @(posedge clk_g) begin
        for (int b = 0; b < `CACHE_WORD_W/8; b++) begin
            if (wstrb[b]) begin
                mem[addr][b*8 +: 8] <= wdata[b*8 +: 8];
            end
        end
    end

    // read-first, old word on a same-cycle write
    always_ff @(posedge clk_g) begin
        rdata <= mem[addr];
    end

endmodule

// ==== hw/cache_way.sv ====
`timescale 1ns/100ps
`include "cache_settings.svh"

module cache_way (
    input  logic                        clk_g,
    input  logic                        resetn,
    input  logic [`CACHE_INDEX_W-1:0]   set_index,
    input  logic [`CACHE_TAG_W-1:0]     lookup_tag,
    input  cache_pkg::way_wr_t          wr,
    output cache_pkg::way_stat_t        stat
);

    logic [`CACHE_SETS-1:0]                     valid_bits;
    logic [`CACHE_SETS-1:0]                     dirty_bits;
    logic [`CACHE_TAG_W-1:0]                    tag_mem [`CACHE_SETS];
    logic [`CACHE_TAG_W-1:0]                    tag_q;
    logic [`CACHE_INDEX_W-1:0]                  index_q;
    logic [`CACHE_BANKS-1:0][`CACHE_WORD_W-1:0] line;

    // line state bits, empty after reset
    always_ff @(posedge clk_g) begin
        if (!resetn) begin
            valid_bits <= '0;
            dirty_bits <= '0;
        end else begin
            if (wr.tag_we) begin
                valid_bits[set_index] <= 1'b1;
            end
            if (wr.dirty_we) begin
                dirty_bits[set_index] <= wr.dirty;
            end
        end
    end

    // tag store, read lines up with the bank outputs
    always_ff @(posedge clk_g) begin
        if (wr.tag_we) begin
            tag_mem[set_index] <= lookup_tag;
        end
        tag_q   <= tag_mem[set_index];
        index_q <= set_index;
    end

    for (genvar b = 0; b < `CACHE_BANKS; b++) begin : g_bank
        bank_ram u_bank (
            .clk_g (clk_g),
            .addr  (set_index),
            .wstrb (wr.wstrb[b]),
            .wdata (wr.wdata),
            .rdata (line[b])
        );
    end

    // status of the set presented last cycle
    always_comb begin
        stat.valid = valid_bits[index_q];
        stat.dirty = dirty_bits[index_q];
        stat.tag   = tag_q;
        stat.hit   = valid_bits[index_q] && (tag_q == lookup_tag);
        stat.line  = line;
    end

endmodule

// ==== hw/cache_ctrl.sv ====
`timescale 1ns/100ps
`include "cache_settings.svh"

module cache_ctrl (
    input  logic                                                   clk_g,
    input  logic                                                   resetn,
    input  cache_pkg::cpu_req_t                                    req,
    input  logic                                                   valid,
    output logic                                                   addr_ok,
    output logic                                                   data_ok,
    output logic [`CACHE_WORD_W-1:0]                               rdata,
    output logic [`CACHE_INDEX_W-1:0]                              set_index,
    output logic [`CACHE_TAG_W-1:0]                                lookup_tag,
    input  cache_pkg::way_stat_t                                   way0_stat,
    input  cache_pkg::way_stat_t                                   way1_stat,
    output cache_pkg::way_wr_t                                     way0_wr,
    output cache_pkg::way_wr_t                                     way1_wr,
    output logic                                                   rd_req,
    output logic [`CACHE_TAG_W+`CACHE_INDEX_W+`CACHE_OFFSET_W-1:0] rd_addr,
    input  logic                                                   rd_rdy,
    input  logic                                                   ret_valid,
    input  logic                                                   ret_last,
    input  logic [`CACHE_WORD_W-1:0]                               ret_data,
    output logic                                                   wr_req,
    output logic [`CACHE_TAG_W+`CACHE_INDEX_W+`CACHE_OFFSET_W-1:0] wr_addr,
    output logic [`CACHE_BANKS*`CACHE_WORD_W-1:0]                  wr_data,
    input  logic                                                   wr_rdy
);
    import cache_pkg::*;

    localparam int BEAT_W = $clog2(`CACHE_BANKS);

    state_t                   state;
    state_t                   state_nxt;
    cpu_req_t                 req_q;
    logic [BEAT_W-1:0]        beat_cnt;
    logic [BEAT_W-1:0]        word_sel;
    logic [2:0]               lfsr;
    logic                     victim;
    logic                     wb_slot;
    logic                     take;
    logic                     hit;
    logic                     write_hit;
    logic                     refill_beat;
    logic                     target_way;
    way_stat_t                hit_stat;
    way_stat_t                victim_stat;
    way_wr_t                  wr_cmd;
    cache_addr_u              rd_addr_u;
    cache_addr_u              wr_addr_u;
    logic [`CACHE_WORD_W-1:0] merged;

    assign take        = (state == IDLE) && valid;
    assign hit         = way0_stat.hit || way1_stat.hit;
    assign write_hit   = (state == LOOKUP) && hit && req_q.op;
    assign refill_beat = (state == REFILL) && ret_valid;
    assign word_sel    = req_q.offset[`CACHE_OFFSET_W-1 -: BEAT_W];
    assign hit_stat    = way0_stat.hit ? way0_stat : way1_stat;
    assign victim_stat = victim ? way1_stat : way0_stat;

    always_ff @(posedge clk_g) begin
        if (!resetn) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (valid) begin
                    state_nxt = LOOKUP;
                end
            end
            LOOKUP: begin
                state_nxt = hit ? IDLE : MISS;
            end
            MISS: begin
                if (wr_rdy) begin
                    state_nxt = REPLACE;
                end
            end
            REPLACE: begin
                if (rd_rdy) begin
                    state_nxt = REFILL;
                end
            end
            REFILL: begin
                if (ret_valid && ret_last) begin
                    state_nxt = IDLE;
                end
            end
            default: begin
                state_nxt = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_g) begin
        if (take) begin
            req_q <= req;
        end
    end

    // victim pick, beat count and the write-back slot
    always_ff @(posedge clk_g) begin
        if (!resetn) begin
            lfsr     <= 3'b000;
            victim   <= 1'b0;
            wb_slot  <= 1'b0;
            beat_cnt <= '0;
        end else begin
            lfsr    <= {lfsr[1:0], lfsr[2] ~^ lfsr[1]};
            wb_slot <= (state == MISS) && wr_rdy;
            if ((state == MISS) && wr_rdy) begin
                victim <= lfsr[1];
            end
            if ((state == REPLACE) && rd_rdy) begin
                beat_cnt <= '0;
            end else if (refill_beat) begin
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

    // store bytes laid over the returning word
    always_comb begin
        merged = ret_data;
        for (int b = 0; b < `CACHE_WORD_W/8; b++) begin
            if (req_q.wstrb[b]) begin
                merged[b*8 +: 8] = req_q.wdata[b*8 +: 8];
            end
        end
    end

    always_comb begin
        wr_cmd = '0;
        if (write_hit) begin
            wr_cmd.wstrb[word_sel] = req_q.wstrb;
            wr_cmd.wdata           = req_q.wdata;
            wr_cmd.dirty_we        = 1'b1;
            wr_cmd.dirty           = 1'b1;
        end else if (refill_beat) begin
            wr_cmd.wstrb[beat_cnt] = '1;
            wr_cmd.wdata           = (req_q.op && (beat_cnt == word_sel)) ? merged : ret_data;
            wr_cmd.tag_we          = ret_last;
            wr_cmd.dirty_we        = ret_last;
            wr_cmd.dirty           = req_q.op;
        end
    end

    // hit way in LOOKUP, victim otherwise
    assign target_way = (state == LOOKUP) ? !way0_stat.hit : victim;
    assign way0_wr    = target_way ? way_wr_t'('0) : wr_cmd;
    assign way1_wr    = target_way ? wr_cmd : way_wr_t'('0);

    assign set_index  = take ? req.index : req_q.index;
    assign lookup_tag = req_q.tag;

    assign addr_ok = (state == IDLE);
    assign data_ok = ((state == LOOKUP) && hit) || (refill_beat && (beat_cnt == word_sel));
    assign rdata   = (state == REFILL) ? ret_data : hit_stat.line[word_sel];

    always_comb begin
        rd_addr_u.fields.tag    = req_q.tag;
        rd_addr_u.fields.index  = req_q.index;
        rd_addr_u.fields.offset = '0;
        wr_addr_u.fields.tag    = victim_stat.tag;
        wr_addr_u.fields.index  = req_q.index;
        wr_addr_u.fields.offset = '0;
    end

    assign rd_req  = (state == REPLACE);
    assign rd_addr = rd_addr_u.word;

    // only a dirty, valid victim goes back to memory
    assign wr_req  = wb_slot && victim_stat.valid && victim_stat.dirty;
    assign wr_addr = wr_addr_u.word;
    assign wr_data = victim_stat.line;

endmodule

// ==== hw/cache_top.sv ====
`timescale 1ns/100ps
`include "cache_settings.svh"

module cache_top (
    input  logic                                                   clk_g,
    input  logic                                                   resetn,
    // cpu side
    input  logic                                                   valid,
    input  logic                                                   op,
    input  logic [`CACHE_INDEX_W-1:0]                              index,
    input  logic [`CACHE_TAG_W-1:0]                                tag,
    input  logic [`CACHE_OFFSET_W-1:0]                             offset,
    input  logic [`CACHE_WORD_W/8-1:0]                             wstrb,
    input  logic [`CACHE_WORD_W-1:0]                               wdata,
    output logic                                                   addr_ok,
    output logic                                                   data_ok,
    output logic [`CACHE_WORD_W-1:0]                               rdata,
    // memory read side
    output logic                                                   rd_req,
    output logic [`CACHE_TAG_W+`CACHE_INDEX_W+`CACHE_OFFSET_W-1:0] rd_addr,
    input  logic                                                   rd_rdy,
    input  logic                                                   ret_valid,
    input  logic                                                   ret_last,
    input  logic [`CACHE_WORD_W-1:0]                               ret_data,
    // memory write side
    output logic                                                   wr_req,
    output logic [`CACHE_TAG_W+`CACHE_INDEX_W+`CACHE_OFFSET_W-1:0] wr_addr,
    output logic [`CACHE_BANKS*`CACHE_WORD_W-1:0]                  wr_data,
    input  logic                                                   wr_rdy
);
    import cache_pkg::*;

    cpu_req_t                  req;
    way_stat_t                 way0_stat;
    way_stat_t                 way1_stat;
    way_wr_t                   way0_wr;
    way_wr_t                   way1_wr;
    logic [`CACHE_INDEX_W-1:0] set_index;
    logic [`CACHE_TAG_W-1:0]   lookup_tag;

    assign req = '{
        op:     op,
        tag:    tag,
        index:  index,
        offset: offset,
        wstrb:  wstrb,
        wdata:  wdata
    };

    cache_ctrl u_ctrl (
        .clk_g      (clk_g),
        .resetn     (resetn),
        .req        (req),
        .valid      (valid),
        .addr_ok    (addr_ok),
        .data_ok    (data_ok),
        .rdata      (rdata),
        .set_index  (set_index),
        .lookup_tag (lookup_tag),
        .way0_stat  (way0_stat),
        .way1_stat  (way1_stat),
        .way0_wr    (way0_wr),
        .way1_wr    (way1_wr),
        .rd_req     (rd_req),
        .rd_addr    (rd_addr),
        .rd_rdy     (rd_rdy),
        .ret_valid  (ret_valid),
        .ret_last   (ret_last),
        .ret_data   (ret_data),
        .wr_req     (wr_req),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .wr_rdy     (wr_rdy)
    );

    cache_way way0 (
        .clk_g      (clk_g),
        .resetn     (resetn),
        .set_index  (set_index),
        .lookup_tag (lookup_tag),
        .wr         (way0_wr),
        .stat       (way0_stat)
    );

    cache_way way1 (
        .clk_g      (clk_g),
        .resetn     (resetn),
        .set_index  (set_index),
        .lookup_tag (lookup_tag),
        .wr         (way1_wr),
        .stat       (way1_stat)
    );

endmodule

// ==== testbench/mem_model.sv ====
`timescale 1ns/100ps
`include "cache_settings.svh"

module mem_model #(
    parameter int WORDS = 8192,
    parameter int SEED  = 32'h7285_3854
) (
    input  logic                                                   clk_g,
    input  logic                                                   resetn,
    input  logic                                                   rd_req,
    input  logic [`CACHE_TAG_W+`CACHE_INDEX_W+`CACHE_OFFSET_W-1:0] rd_addr,
    output logic                                                   rd_rdy = 1'b0,
    output logic                                                   ret_valid = 1'b0,
    output logic                                                   ret_last = 1'b0,
    output logic [`CACHE_WORD_W-1:0]                               ret_data = '0,
    input  logic                                                   wr_req,
    input  logic [`CACHE_TAG_W+`CACHE_INDEX_W+`CACHE_OFFSET_W-1:0] wr_addr,
    input  logic [`CACHE_BANKS*`CACHE_WORD_W-1:0]                  wr_data,
    output logic                                                   wr_rdy = 1'b0
);

    logic [`CACHE_WORD_W-1:0] image [WORDS];
    integer                   seed = SEED;
    int                       beat;
    logic                     busy;
    logic [12:0]              base;

    // unwritten words hold their byte address xor a marker
    initial begin
        for (int i = 0; i < WORDS; i++) begin
            image[i] = (i << 2) ^ 32'hC0DE_0000;
        end
    end

    always @(posedge clk_g) begin
        if (!resetn) begin
            rd_rdy    <= 1'b0;
            ret_valid <= 1'b0;
            ret_last  <= 1'b0;
            ret_data  <= '0;
            wr_rdy    <= 1'b0;
            busy      <= 1'b0;
            beat      <= 0;
        end else begin
            wr_rdy    <= ($random(seed) & 3) != 0;
            rd_rdy    <= 1'b0;
            ret_valid <= 1'b0;
            ret_last  <= 1'b0;
            if (wr_req) begin
                for (int b = 0; b < `CACHE_BANKS; b++) begin
                    image[{wr_addr[14:4], 2'b00} + b] = wr_data[b*`CACHE_WORD_W +: `CACHE_WORD_W];
                end
            end
            // stall rd_rdy and then return four beats with gaps
            if (!busy && rd_req && !rd_rdy && (($random(seed) & 3) == 0)) begin
                rd_rdy <= 1'b1;
            end else if (!busy && rd_req && rd_rdy) begin
                busy <= 1'b1;
                beat <= 0;
                base <= {rd_addr[14:4], 2'b00};
            end else if (busy && ($random(seed) & 1)) begin
                ret_valid <= 1'b1;
                ret_last  <= (beat == `CACHE_BANKS-1);
                ret_data  <= image[base + beat];
                beat      <= beat + 1;
                busy      <= (beat != `CACHE_BANKS-1);
            end
        end
    end

endmodule

// ==== testbench/cache_assert.sv ====
`timescale 1ns/100ps
`include "cache_settings.svh"

module cache_assert (
    input logic                                                   clk_g,
    input logic                                                   resetn,
    input logic                                                   valid,
    input logic                                                   addr_ok,
    input logic                                                   data_ok,
    input logic                                                   rd_req,
    input logic                                                   rd_rdy,
    input logic [`CACHE_TAG_W+`CACHE_INDEX_W+`CACHE_OFFSET_W-1:0] rd_addr,
    input logic                                                   wr_req,
    input cache_pkg::state_t                                      state
);
    import cache_pkg::*;

    logic pending;
    int   err_count = 0;

    // a request taken and not answered yet
    always_ff @(posedge clk_g) begin
        if (!resetn) begin
            pending <= 1'b0;
        end else if (valid && addr_ok) begin
            pending <= 1'b1;
        end else if (data_ok) begin
            pending <= 1'b0;
        end
    end

    assert property (@(posedge clk_g) $rose(resetn) |-> addr_ok && !data_ok && !rd_req && !wr_req)
    else begin
        $error("port outputs are not idle in the first cycle after reset");
        err_count++;
    end

    // write-back is one pulse, straight after MISS
    assert property (@(posedge clk_g) disable iff (!resetn) wr_req |=> !wr_req)
    else begin
        $error("wr_req is high for more than one cycle");
        err_count++;
    end

    assert property (@(posedge clk_g) disable iff (!resetn) wr_req |-> $past(state) == MISS)
    else begin
        $error("wr_req rose outside the first REPLACE cycle");
        err_count++;
    end

    assert property (@(posedge clk_g) disable iff (!resetn)
        rd_req && !rd_rdy |=> rd_req && $stable(rd_addr))
    else begin
        $error("rd_req dropped or rd_addr changed before rd_rdy");
        err_count++;
    end

    assert property (@(posedge clk_g) disable iff (!resetn) data_ok |-> pending)
    else begin
        $error("data_ok without a taken request");
        err_count++;
    end

endmodule

bind cache_top cache_assert u_assert (.*, .state(u_ctrl.state));

// ==== testbench/cache_tb.sv ====
`timescale 1ns/100ps
`include "cache_settings.svh"

module cache_tb;

    localparam int N_REQ     = 300;
    localparam int REQ_LIMIT = 60;
    localparam int PERIOD    = 100;
    localparam int WORDS     = 8192;
    localparam int SEED      = 32'h7285_3854;

    logic                                                   clk_g = 1'b0;
    logic                                                   resetn = 1'b0;
    logic                                                   valid = 1'b0;
    logic                                                   op = 1'b0;
    logic [`CACHE_INDEX_W-1:0]                              index = '0;
    logic [`CACHE_TAG_W-1:0]                                tag = '0;
    logic [`CACHE_OFFSET_W-1:0]                             offset = '0;
    logic [`CACHE_WORD_W/8-1:0]                             wstrb = '0;
    logic [`CACHE_WORD_W-1:0]                               wdata = '0;
    logic                                                   addr_ok;
    logic                                                   data_ok;
    logic [`CACHE_WORD_W-1:0]                               rdata;
    logic                                                   rd_req;
    logic [`CACHE_TAG_W+`CACHE_INDEX_W+`CACHE_OFFSET_W-1:0] rd_addr;
    logic                                                   rd_rdy;
    logic                                                   ret_valid;
    logic                                                   ret_last;
    logic [`CACHE_WORD_W-1:0]                               ret_data;
    logic                                                   wr_req;
    logic [`CACHE_TAG_W+`CACHE_INDEX_W+`CACHE_OFFSET_W-1:0] wr_addr;
    logic [`CACHE_BANKS*`CACHE_WORD_W-1:0]                  wr_data;
    logic                                                   wr_rdy;

    logic [`CACHE_WORD_W-1:0]  shadow [WORDS];
    logic [`CACHE_INDEX_W-1:0] index_pool [3] = '{8'h03, 8'h7C, 8'hE1};
    integer                    seed = SEED;

    always #(PERIOD/2) clk_g = ~clk_g;

    cache_top DUT (.*);

    mem_model #(.WORDS(WORDS), .SEED(SEED)) u_mem (.*);

    // one random request starting right after a rising edge
    task automatic run_request(input int n);
        logic [`CACHE_TAG_W-1:0]    t;
        logic [`CACHE_INDEX_W-1:0]  s;
        logic [1:0]                 ws;
        logic                       is_store;
        logic [`CACHE_WORD_W/8-1:0] strb;
        logic [`CACHE_WORD_W-1:0]   data;
        logic [12:0]                w;
        logic [`CACHE_WORD_W-1:0]   expect_word;
        t        = $unsigned($random(seed)) % 5;
        s        = index_pool[$unsigned($random(seed)) % 3];
        ws       = $random(seed);
        is_store = $random(seed);
        strb     = $random(seed);
        data     = $random(seed);
        w        = {t[2:0], s, ws};
        valid  <= 1'b1;
        op     <= is_store;
        tag    <= t;
        index  <= s;
        offset <= {ws, 2'b00};
        wstrb  <= is_store ? strb : '0;
        wdata  <= data;
        @(posedge clk_g);
        while (!addr_ok) @(posedge clk_g);
        valid <= 1'b0;
        expect_word = shadow[w];
        if (is_store) begin
            for (int b = 0; b < `CACHE_WORD_W/8; b++) begin
                if (strb[b]) begin
                    shadow[w][b*8 +: 8] = data[b*8 +: 8];
                end
            end
        end
        @(posedge clk_g);
        while (!data_ok) @(posedge clk_g);
        if (!is_store) begin
            assert (rdata == expect_word)
            else begin
                $display("FAIL read_data req %0d: expected %h, actual %h", n, expect_word, rdata);
                $display("sim failed");
                $fatal(1, "read data mismatch");
            end
        end
    endtask

    initial begin
        for (int i = 0; i < WORDS; i++) begin
            shadow[i] = (i << 2) ^ 32'hC0DE_0000;
        end
        repeat (4) @(posedge clk_g);
        resetn <= 1'b1;
        for (int n = 0; n < N_REQ; n++) begin
            run_request(n);
        end
        if (DUT.u_assert.err_count == 0) begin
            $display("sim passed");
            $finish;
        end else begin
            $display("%0d handshake assertions failed", DUT.u_assert.err_count);
            $display("sim failed");
            $fatal(1, "assertion errors");
        end
    end

    // stop at the first handshake assertion failure
    initial begin
        wait (DUT.u_assert.err_count != 0);
        $display("a handshake assertion on the cache ports failed");
        $display("sim failed");
        $fatal(1, "handshake assertion error");
    end

    // limit for the whole run
    initial begin
        #(N_REQ * REQ_LIMIT * PERIOD);
        $display("timeout: the cache stopped answering requests");
        $display("sim failed");
        $fatal(1, "watchdog expired");
    end

endmodule

// ==== build.f ====
+incdir+hw
hw/cache_pkg.sv
hw/bank_ram.sv
hw/cache_way.sv
hw/cache_ctrl.sv
hw/cache_top.sv
testbench/mem_model.sv
testbench/cache_assert.sv
testbench/cache_tb.sv
